// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -Wno-fatal
TOP       ?= board_top_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/bench_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module bench_checker #(
    parameter int tick_period = 3000
)(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [7:0]  key_n,
    input  logic [7:0]  sw,
    input  logic [15:0] led,
    input  logic [7:0]  abcdefgh,
    input  logic [5:0]  digit_n,
    input  logic        mic_sck,
    input  logic        mic_ws,
    input  logic        mic_lr,
    input  logic [23:0] sent_word,
    output int          check_count,
    output int          err_count
);

    int          cyc;         // Posedges since reset release
    logic [7:0]  sw_q;
    logic [7:0]  key_q;
    logic        prev_ws;
    logic        prev_sck;
    logic        first_fall;
    int          rise_cnt;    // Rising sck in the current left slot
    int          period_cnt;  // Rising sck per frame
    logic        pend_peak;
    logic        pend_load;
    logic [23:0] word_q;
    logic [22:0] peak;        // Model peak
    logic [23:0] disp_cur;
    logic [23:0] disp_prev;
    logic [15:0] led_exp;
    logic [5:0]  sel;
    logic [4:0]  dec;
    int          idx;

    function automatic logic [22:0] magnitude(input logic [23:0] w);
        logic [23:0] neg;
        neg = ~w + 24'd1;
        if (!w[23])
            return w[22:0];
        else if (w == 24'h800000)
            return '1;                          // Saturates
        else
            return neg[22:0];
    endfunction

    function automatic logic [15:0] thermometer(input logic [22:0] p);
        int n;
        n = int'(p) / (1 << 19);
        if (n > 16)
            n = 16;
        return 16'((32'd1 << n) - 1);
    endfunction

    // Bit 4 flags a valid hex glyph
    function automatic logic [4:0] glyph_value(input logic [7:0] g);
        case (g)
            8'hfc: return 5'h10;
            8'h60: return 5'h11;
            8'hda: return 5'h12;
            8'hf2: return 5'h13;
            8'h66: return 5'h14;
            8'hb6: return 5'h15;
            8'hbe: return 5'h16;
            8'he0: return 5'h17;
            8'hfe: return 5'h18;
            8'hf6: return 5'h19;
            8'hee: return 5'h1a;
            8'h3e: return 5'h1b;
            8'h9c: return 5'h1c;
            8'h7a: return 5'h1d;
            8'h9e: return 5'h1e;
            8'h8e: return 5'h1f;
            default: return 5'h00;
        endcase
    endfunction

    // Inputs captured where the DUT samples them
    always @(posedge clk) begin
        sw_q  <= sw;
        key_q <= ~key_n;
        cyc   <= arst_n ? cyc + 1 : 0;
    end

    // ------------------------------------------------------------------------
    // Model and compare, once per clock on the falling edge
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        if (arst_n !== 1'b1) begin
            prev_ws    = 1'b1;
            prev_sck   = 1'b0;
            first_fall = 1'b1;
            rise_cnt   = 0;
            period_cnt = 0;
            pend_peak  = 1'b0;
            pend_load  = 1'b0;
            peak       = '0;
            disp_cur   = '0;
            disp_prev  = '0;
        end else begin
            check_count++;
            if (mic_lr) begin
                $display("[ERROR] %0t: mic_lr is high", $time);
                err_count++;
            end
            if (mic_ws != prev_ws && mic_sck) begin
                $display("[ERROR] %0t: mic_ws changed while mic_sck high", $time);
                err_count++;
            end

            // Display load sees peak from before this edge
            if (pend_load && !key_q[0]) begin
                disp_prev = disp_cur;
                disp_cur  = sw_q[0] ? {1'b0, peak} : word_q;
            end
            if (pend_peak) begin
                if (magnitude(word_q) > peak)
                    peak = magnitude(word_q);
            end else if (cyc > 1 && cyc % tick_period == 1) begin
                peak = (peak >= 23'(1 << 19)) ? peak - 23'(1 << 19) : '0;   // Decay step
            end
            pend_load = pend_peak;
            pend_peak = 1'b0;

            // Frame tracking from the pins
            if (!mic_ws && prev_ws) begin
                if (!first_fall && period_cnt != 64) begin
                    $display("[ERROR] %0t: ws period %0d sck, expected 64", $time, period_cnt);
                    err_count++;
                end
                first_fall = 1'b0;
                rise_cnt   = 0;
                period_cnt = 0;
            end
            if (mic_sck && !prev_sck) begin
                period_cnt++;
                if (!mic_ws) begin
                    rise_cnt++;
                    if (rise_cnt == 25) begin   // Skip bit plus 24 data bits
                        pend_peak = 1'b1;
                        word_q    = sent_word;
                    end
                end
            end
            prev_ws  = mic_ws;
            prev_sck = mic_sck;

            led_exp = thermometer(peak);
            if (led !== led_exp) begin
                $display("[ERROR] %0t: led %h, expected %h", $time, led, led_exp);
                err_count++;
            end

            sel = ~digit_n;
            if (!$onehot(sel)) begin
                $display("[ERROR] %0t: digit select %b not one-hot", $time, sel);
                err_count++;
            end else if (cyc > 2) begin
                idx = $clog2(sel);
                dec = glyph_value(abcdefgh);
                if (!dec[4] || (dec[3:0] != disp_cur[4 * idx +: 4]
                        && dec[3:0] != disp_prev[4 * idx +: 4])) begin
                    $display("[ERROR] %0t: digit %0d shows %h, expected %h", $time, idx,
                             abcdefgh, disp_cur[4 * idx +: 4]);
                    err_count++;
                end
            end
        end
    end

    initial begin
        check_count = 0;
        err_count   = 0;
        word_q      = '0;
    end

endmodule

`default_nettype wire

// ==== bench/board_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top_tb;

    localparam int clk_mhz     = 50;
    localparam int tick_hz     = 16_667;                    // About 3000 clocks per tick
    localparam int tick_period = clk_mhz * 1_000_000 / tick_hz;
    localparam int sck_div     = 2;
    localparam int refresh_div = 4;
    localparam int n_frames    = 60;
    localparam int max_cycles  = n_frames * 64 * 2 * sck_div + 2000;   // Plus margin

    logic        clk;
    logic        arst_n;
    logic [7:0]  key_n;
    logic [7:0]  sw;
    logic        mic_sd;
    logic [15:0] led;
    logic [7:0]  abcdefgh;
    logic [5:0]  digit_n;
    logic        mic_sck;
    logic        mic_ws;
    logic        mic_lr;

    logic [31:0] rng;           // LCG state
    logic [23:0] cur_word;      // Word going out in this left slot
    logic        prev_ws;
    logic        prev_sck;
    int          bit_idx;       // Falling sck count within the left slot
    int          frame_no;
    int          cycles;
    int          check_count;
    int          err_count;

    board_top #(
        .clk_mhz     ( clk_mhz     ),
        .tick_hz     ( tick_hz     ),
        .refresh_div ( refresh_div ),
        .sck_div     ( sck_div     )
    ) uut (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .key_n    ( key_n    ),
        .sw       ( sw       ),
        .mic_sd   ( mic_sd   ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit_n  ( digit_n  ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_lr   ( mic_lr   )
    );

    bench_checker #(
        .tick_period ( tick_period )
    ) chk (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .key_n       ( key_n       ),
        .sw          ( sw          ),
        .led         ( led         ),
        .abcdefgh    ( abcdefgh    ),
        .digit_n     ( digit_n     ),
        .mic_sck     ( mic_sck     ),
        .mic_ws      ( mic_ws      ),
        .mic_lr      ( mic_lr      ),
        .sent_word   ( cur_word    ),
        .check_count ( check_count ),
        .err_count   ( err_count   )
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // New word per left slot, new switches and keys every 8 frames
    task automatic start_frame();
        logic [23:0] w;
        rng = lcg_next(rng);
        w   = rng[31:8];
        if (frame_no % 32 == 21)
            w = 24'h800000;                    // Most negative word
        else if (frame_no % 32 < 16)
            w = {{6{w[23]}}, w[23:6]};         // Quiet stretch, peak floors at the next tick
        if (frame_no % 8 == 0) begin
            rng   = lcg_next(rng);
            sw    = rng[23:16];
            key_n = ~{rng[14:8], rng[7:6] == 2'b00};   // key[0] held a quarter of the time
        end
        cur_word = w;
        frame_no++;
    endtask

    // ------------------------------------------------------------------------
    // Clock and reset
    // ------------------------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rng      = 32'd76;
        arst_n   = 1'b0;
        key_n    = '1;
        sw       = '0;
        mic_sd   = 1'b0;
        cur_word = '0;
        frame_no = 0;
        bit_idx  = 0;
        prev_ws  = 1'b1;
        prev_sck = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

    // ------------------------------------------------------------------------
    // Microphone model, sd moves after each falling sck
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        if (arst_n !== 1'b1) begin
            prev_ws  = 1'b1;   // Slot after reset counts as a fresh frame
            prev_sck = 1'b0;
            mic_sd   = 1'b0;
        end else begin
            if (!mic_ws && prev_ws) begin
                start_frame();
                bit_idx = 0;
            end else if (prev_sck && !mic_sck && !mic_ws) begin
                bit_idx++;
            end
            if (!mic_ws && bit_idx >= 1 && bit_idx <= 24)
                mic_sd = cur_word[24 - bit_idx];   // MSB after the first fall
            else
                mic_sd = 1'b0;
            prev_ws  = mic_ws;
            prev_sck = mic_sck;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        cycles = 0;
        wait (frame_no == n_frames + 1);   // Last full frame received
        repeat (20) @(negedge clk);
        $display("Checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    localparam int sample_w = 24;   // INMP441 word length

    // Two's complement microphone word
    typedef logic signed [sample_w - 1:0] sample_t;

    // Absolute value, one bit narrower
    typedef logic [sample_w - 2:0] magnitude_t;

    // Strobe plus word, receiver to meter and display hold
    typedef struct packed {
        logic    valid;   // One clock wide
        sample_t value;   // Held until the next strobe
    } mic_sample_t;

    // One LED worth of level, also one decay step
    localparam int level_step = 1 << 19;

    typedef enum logic [1:0] {
        wait_frame,   // Right slot or start-up
        skip_bit,     // First bit clock of the left slot carries no data
        shift,        // 24 data bits, MSB first
        idle_slot     // Rest of the left slot
    } rx_state_t;

endpackage

`default_nettype wire

// ==== logic/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // ------------------------------------------------------------------------
    // Board I/O widths
    // ------------------------------------------------------------------------

    localparam int w_key   = 8;
    localparam int w_sw    = 8;
    localparam int w_led   = 16;
    localparam int w_digit = 6;
    localparam int w_seg   = 8;   // a..g plus dot

    typedef logic [w_key   - 1:0] key_t;        // Active high after the top level
    typedef logic [w_sw    - 1:0] sw_t;
    typedef logic [w_led   - 1:0] led_t;
    typedef logic [w_seg   - 1:0] segments_t;   // abcdefgh, a is MSB
    typedef logic [w_digit - 1:0] digit_sel_t;  // One-hot, digit 0 is bit 0
    typedef logic [3:0]           nibble_t;

    // Everything the seven-segment scan drives, kept in step
    typedef struct packed {
        segments_t  abcdefgh;
        digit_sel_t digit;
    } disp_out_t;

endpackage

`default_nettype wire

// ==== logic/board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top
    import board_pkg::*;
#(
    parameter int clk_mhz     = 50,
    parameter int tick_hz     = 8,        // Peak decay rate
    parameter int refresh_div = 50_000,   // Clocks per digit, 1 kHz at 50 MHz
    parameter int sck_div     = 8         // About 3.1 MHz bit clock
)(
    input  logic       clk,
    input  logic       arst_n,

    input  key_t       key_n,     // Low when pressed
    input  sw_t        sw,

    input  logic       mic_sd,

    output led_t       led,
    output segments_t  abcdefgh,
    output digit_sel_t digit_n,   // Common anode, low selects

    output logic       mic_sck,
    output logic       mic_ws,
    output logic       mic_lr
);

    logic      slow_tick;
    key_t      key;
    disp_out_t disp;

    assign key = ~key_n;   // Lab side sees pressed as 1

    // ------------------------------------------------------------------------
    // Decay tick, one enable pulse in the clk domain
    // ------------------------------------------------------------------------

    tick_gen #(
        .clk_mhz ( clk_mhz ),
        .tick_hz ( tick_hz )
    ) i_tick_gen (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .slow_tick ( slow_tick )
    );

    lab_top #(
        .sck_div     ( sck_div     ),
        .refresh_div ( refresh_div )
    ) i_lab_top (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .slow_tick ( slow_tick ),
        .key       ( key       ),
        .sw        ( sw        ),
        .mic_sd    ( mic_sd    ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .led       ( led       ),
        .disp      ( disp      )
    );

    assign abcdefgh = disp.abcdefgh;
    assign digit_n  = ~disp.digit;

    assign mic_lr = 1'b0;   // Microphone answers in the left slot

endmodule

`default_nettype wire

// ==== logic/i2s_mic_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_mic_receiver
    import audio_pkg::*;
#(
    parameter int sck_div = 8   // Clocks per sck half period, 2 or more
)(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        sd,
    output logic        sck,
    output logic        ws,
    output mic_sample_t sample
);

    localparam int div_w = (sck_div > 1) ? $clog2(sck_div) : 1;

    logic [div_w - 1:0] div_cnt;
    logic               half_end;   // Last clock of an sck half period
    logic               rise_en;
    logic               fall_en;
    logic [5:0]         slot_cnt;   // sck periods within the 64-bit frame
    rx_state_t          state;
    logic [4:0]         bit_cnt;    // Data bits taken so far
    logic [22:0]        shreg;
    logic               valid;
    sample_t            value;

    // ------------------------------------------------------------------------
    // Bit clock and word select
    // ------------------------------------------------------------------------

    assign half_end = (div_cnt == div_w'(sck_div - 1));
    assign rise_en  = half_end && !sck;   // sck goes high on this edge
    assign fall_en  = half_end && sck;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt  <= '0;
            sck      <= 1'b0;
            slot_cnt <= '0;
        end else begin
            if (half_end) begin
                div_cnt <= '0;
                sck     <= ~sck;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (fall_en)
                slot_cnt <= slot_cnt + 1'b1;   // Wraps every frame
        end
    end

    assign ws = slot_cnt[5];   // Low for periods 0..31, the left slot

    // ------------------------------------------------------------------------
    // Slot FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= wait_frame;
            bit_cnt <= '0;
            valid   <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                wait_frame: if (slot_cnt == '0 && !sck) state <= skip_bit;  // Low phase, period 0
                skip_bit: begin
                    if (rise_en) begin   // Unused first bit
                        state   <= shift;
                        bit_cnt <= '0;
                    end
                end
                shift: begin
                    if (rise_en) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 5'd23) begin   // LSB taken
                            state <= idle_slot;
                            valid <= 1'b1;
                        end
                    end
                end
                idle_slot: if (ws) state <= wait_frame;   // Right slot started
                default:   state <= wait_frame;
            endcase
        end
    end

    // Data path, sampled on rising sck
    always_ff @(posedge clk) begin
        if (state == shift && rise_en) begin
            shreg <= {shreg[21:0], sd};
            if (bit_cnt == 5'd23)
                value <= {shreg, sd};   // Full word, MSB first
        end
    end

    assign sample = '{valid: valid, value: value};

    // Strobe only after the 24th shift
    assert property (@(posedge clk) disable iff (!arst_n)
        sample.valid |-> ($past(state) == shift) && (state == idle_slot));

    // Word select moves with the falling bit clock only
    assert property (@(posedge clk) disable iff (!arst_n)
        $changed(ws) |-> $fell(sck));

endmodule

`default_nettype wire

// ==== logic/lab_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lab_top
    import board_pkg::*;
    import audio_pkg::*;
#(
    parameter int sck_div     = 8,
    parameter int refresh_div = 50_000
)(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      slow_tick,
    input  key_t      key,
    input  sw_t       sw,
    input  logic      mic_sd,
    output logic      mic_sck,
    output logic      mic_ws,
    output led_t      led,
    output disp_out_t disp
);

    mic_sample_t sample;
    magnitude_t  peak;
    logic        load_pend;    // Strobe delayed so peak has settled
    logic [23:0] disp_value;

    i2s_mic_receiver #(
        .sck_div ( sck_div )
    ) i_mic (
        .clk    ( clk     ),
        .arst_n ( arst_n  ),
        .sd     ( mic_sd  ),
        .sck    ( mic_sck ),
        .ws     ( mic_ws  ),
        .sample ( sample  )
    );

    level_meter i_meter (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .slow_tick ( slow_tick ),
        .sample    ( sample    ),
        .peak      ( peak      ),
        .led       ( led       )
    );

    // ------------------------------------------------------------------------
    // Display hold, sw[0] picks peak over raw word, key[0] freezes
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_pend  <= 1'b0;
            disp_value <= '0;   // Shows 000000
        end else begin
            load_pend <= sample.valid;
            if (load_pend && !key[0])
                disp_value <= sw[0] ? {1'b0, peak} : sample.value;
        end
    end

    seven_seg_display #(
        .refresh_div ( refresh_div )
    ) i_display (
        .clk    ( clk        ),
        .arst_n ( arst_n     ),
        .value  ( disp_value ),
        .disp   ( disp       )
    );

endmodule

`default_nettype wire

// ==== logic/level_meter.sv ====
`timescale 1ns/1ps
`default_nettype none

module level_meter
    import board_pkg::*;
    import audio_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        slow_tick,
    input  mic_sample_t sample,
    output magnitude_t  peak,
    output led_t        led
);

    sample_t    neg;
    magnitude_t mag;

    // ------------------------------------------------------------------------
    // Magnitude
    // ------------------------------------------------------------------------

    always_comb begin
        neg = -sample.value;
        if (!sample.value[23])
            mag = sample.value[22:0];   // Already positive
        else if (neg[23])
            mag = '1;                   // Most negative word, saturate
        else
            mag = neg[22:0];
    end

    // ------------------------------------------------------------------------
    // Peak hold with slow decay
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            peak <= '0;
        end else if (sample.valid) begin   // Strobe wins over tick
            if (mag > peak)
                peak <= mag;
        end else if (slow_tick) begin
            if (peak >= magnitude_t'(level_step))
                peak <= peak - magnitude_t'(level_step);
            else
                peak <= '0;                // Floor
        end
    end

    // Thermometer bar, bit 0 lights first
    always_comb begin
        for (int i = 0; i < w_led; i++) begin
            led[i] = int'(peak) >= (i + 1) * level_step;
        end
    end

    // Peak never ends up below the word just taken
    assert property (@(posedge clk) disable iff (!arst_n)
        sample.valid |=> peak >= $past(mag));

endmodule

`default_nettype wire

// ==== logic/seven_seg_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module seven_seg_display
    import board_pkg::*;
#(
    parameter int refresh_div = 50_000   // Clocks each digit stays lit
)(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [23:0] value,
    output disp_out_t   disp
);

    localparam int ref_w = (refresh_div > 1) ? $clog2(refresh_div) : 1;

    logic [ref_w - 1:0] ref_cnt;
    digit_sel_t         sel;
    nibble_t            nib;

    // Hex glyphs, a is bit 7, dot stays dark
    function automatic segments_t hex_glyph(input nibble_t n);
        case (n)
            4'h0: hex_glyph = 8'b1111_1100;
            4'h1: hex_glyph = 8'b0110_0000;
            4'h2: hex_glyph = 8'b1101_1010;
            4'h3: hex_glyph = 8'b1111_0010;
            4'h4: hex_glyph = 8'b0110_0110;
            4'h5: hex_glyph = 8'b1011_0110;
            4'h6: hex_glyph = 8'b1011_1110;
            4'h7: hex_glyph = 8'b1110_0000;
            4'h8: hex_glyph = 8'b1111_1110;
            4'h9: hex_glyph = 8'b1111_0110;
            4'ha: hex_glyph = 8'b1110_1110;
            4'hb: hex_glyph = 8'b0011_1110;   // Lower case b
            4'hc: hex_glyph = 8'b1001_1100;
            4'hd: hex_glyph = 8'b0111_1010;   // Lower case d
            4'he: hex_glyph = 8'b1001_1110;
            default: hex_glyph = 8'b1000_1110;   // F
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Scan, digit 0 up to digit 5
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ref_cnt <= '0;
            sel     <= digit_sel_t'(1);
        end else if (ref_cnt == ref_w'(refresh_div - 1)) begin
            ref_cnt <= '0;
            sel     <= {sel[w_digit - 2:0], sel[w_digit - 1]};   // Rotate left
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    // Nibble under the current select
    always_comb begin
        nib = '0;
        for (int i = 0; i < w_digit; i++) begin
            if (sel[i])
                nib = value[4 * i +: 4];
        end
    end

    // Glyph and select leave through one register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            disp <= '{abcdefgh: hex_glyph(4'h0), digit: digit_sel_t'(1)};
        else
            disp <= '{abcdefgh: hex_glyph(nib), digit: sel};
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot(disp.digit));

endmodule

`default_nettype wire

// ==== logic/tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
    parameter int clk_mhz = 50,
    parameter int tick_hz = 8
)(
    input  logic clk,
    input  logic arst_n,
    output logic slow_tick
);

    localparam int period = clk_mhz * 1_000_000 / tick_hz;   // Clocks per tick
    localparam int cnt_w  = (period > 1) ? $clog2(period) : 1;

    logic [cnt_w - 1:0] cnt;

    // Down-counter, tick registered on the zero cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt       <= cnt_w'(period - 1);
            slow_tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt       <= cnt_w'(period - 1);   // Reload
            slow_tick <= 1'b1;
        end else begin
            cnt       <= cnt - 1'b1;
            slow_tick <= 1'b0;
        end
    end

    // Downstream decays once per pulse, never twice back to back
    assert property (@(posedge clk) disable iff (!arst_n)
        slow_tick |=> !slow_tick);

endmodule

`default_nettype wire

// ==== sources.f ====
logic/board_pkg.sv
logic/audio_pkg.sv
logic/tick_gen.sv
logic/i2s_mic_receiver.sv
logic/level_meter.sv
logic/seven_seg_display.sv
logic/lab_top.sv
logic/board_top.sv
bench/bench_checker.sv
bench/board_top_tb.sv
